/* logic/eeprom_pkg.sv */
package eeprom_pkg;

    // 24C16 style array, 2k x 8
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // device type code, first nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // commands from the sequencer to the bit engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0, // start or repeated start
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2, // byte out, ack sampled in slot 9
        CMD_READ  = 2'd3  // byte in, not-ack sent in slot 9
    } i2c_cmd_t;

endpackage

/* logic/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int SCL_HALF_CYCLES = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          cmd_valid,
    input  eeprom_pkg::i2c_cmd_t          cmd,
    input  logic [eeprom_pkg::DATA_W-1:0] cmd_byte,
    input  logic                          sda_in,
    output logic                          scl,
    output logic                          sda_low,
    output logic                          cmd_done,
    output logic [eeprom_pkg::DATA_W-1:0] rx_byte,
    output logic                          nack
);
    import eeprom_pkg::*;

    localparam int CNT_W = $clog2(SCL_HALF_CYCLES);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(SCL_HALF_CYCLES - 1);
    localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(SCL_HALF_CYCLES / 2 - 1);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_HEAD,   // start condition
        PH_STOP,
        PH_SH8OUT, // byte write plus ack slot
        PH_SH8IN   // byte read plus not-ack slot
    } phase_t;

    phase_t            phase;
    logic              high_half; // second half of a slot, scl high
    logic [CNT_W-1:0]  hcnt;
    logic [3:0]        bitcnt;    // 0..7 data, 8 ack
    logic [DATA_W-1:0] shreg;

    logic half_end;
    logic slot_end;
    logic low_start;
    logic mid_high;
    logic ack_slot;
    logic last_slot;

    assign half_end  = (phase != PH_IDLE) && (hcnt == LAST_CNT);
    assign slot_end  = half_end && high_half;
    assign low_start = (phase != PH_IDLE) && !high_half && (hcnt == '0);
    assign mid_high  = high_half && (hcnt == MID_CNT);
    assign ack_slot  = (bitcnt == 4'd8);
    assign last_slot = (phase == PH_HEAD) || (phase == PH_STOP) || ack_slot;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase     <= PH_IDLE;
            high_half <= 1'b0;
            hcnt      <= '0;
            bitcnt    <= '0;
            scl       <= 1'b1;
            sda_low   <= 1'b0;
            cmd_done  <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (phase == PH_IDLE)
            begin
                if (cmd_valid)
                begin
                    case (cmd)
                        CMD_START: phase <= PH_HEAD;
                        CMD_STOP:  phase <= PH_STOP;
                        CMD_WRITE: phase <= PH_SH8OUT;
                        default:   phase <= PH_SH8IN;
                    endcase
                    high_half <= 1'b0;
                    hcnt      <= '0;
                    bitcnt    <= '0;
                    scl       <= 1'b0; // every command opens with scl low
                end
            end
            else
            begin
                hcnt <= half_end ? '0 : hcnt + 1'b1;
                if (half_end && !high_half)
                begin
                    high_half <= 1'b1;
                    scl       <= 1'b1;
                end
                else if (slot_end)
                begin
                    high_half <= 1'b0;
                    if (last_slot)
                    begin
                        phase    <= PH_IDLE;
                        cmd_done <= 1'b1; // scl left high
                    end
                    else
                    begin
                        bitcnt <= bitcnt + 4'd1;
                        scl    <= 1'b0;
                    end
                end

                // data moves one clock after scl falls
                if (low_start)
                begin
                    case (phase)
                        PH_HEAD:   sda_low <= 1'b0;
                        PH_STOP:   sda_low <= 1'b1;
                        PH_SH8OUT: sda_low <= !ack_slot && !shreg[DATA_W-1];
                        default:   sda_low <= 1'b0; // release, incl. the not-ack
                    endcase
                end
                else if (mid_high && phase == PH_HEAD)
                    sda_low <= 1'b1; // sda falls, scl high
                else if (mid_high && phase == PH_STOP)
                    sda_low <= 1'b0; // sda rises, scl high
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (phase == PH_IDLE && cmd_valid)
            shreg <= cmd_byte;
        else if (slot_end && !ack_slot && (phase == PH_SH8OUT || phase == PH_SH8IN))
            shreg <= {shreg[DATA_W-2:0], sda_in}; // msb first
        if (slot_end && ack_slot)
        begin
            if (phase == PH_SH8OUT)
                nack <= sda_in;
            if (phase == PH_SH8IN)
                rx_byte <= shreg;
        end
    end

    // scl high inside a byte means the data bit is already settled
    property p_sda_stable_scl_high;
        @(posedge CLK) disable iff (RESET)
            (scl && (phase == PH_SH8OUT || phase == PH_SH8IN)) |=> $stable(sda_low);
    endproperty

    a_sda_stable_scl_high: assert property (p_sda_stable_scl_high)
        else $error("sda_low changed while scl high inside a byte");

endmodule

/* logic/eeprom_sequencer.sv */
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    input  logic                          cmd_done,
    input  logic [eeprom_pkg::DATA_W-1:0] rx_byte,
    input  logic                          nack,
    output logic                          cmd_valid,
    output eeprom_pkg::i2c_cmd_t          cmd,
    output logic [eeprom_pkg::DATA_W-1:0] cmd_byte,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          ack,
    output logic                          ack_err,
    output logic                          busy
);
    import eeprom_pkg::*;

    // one-hot, named by the command issued on the next cmd_done
    localparam logic [8:0] IDLE       = 9'b0_0000_0001;
    localparam logic [8:0] CTRL_WRITE = 9'b0_0000_0010;
    localparam logic [8:0] ADDR_WRITE = 9'b0_0000_0100;
    localparam logic [8:0] DATA_WRITE = 9'b0_0000_1000;
    localparam logic [8:0] READ_START = 9'b0_0001_0000;
    localparam logic [8:0] CTRL_READ  = 9'b0_0010_0000;
    localparam logic [8:0] DATA_READ  = 9'b0_0100_0000;
    localparam logic [8:0] STOP       = 9'b0_1000_0000;
    localparam logic [8:0] ACKN       = 9'b1_0000_0000;

    logic [8:0]        state;
    logic              wf;        // 1 write, 0 random read
    logic              nack_seen;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              byte_sent;
    logic [DATA_W-1:0] ctrl_wr;
    logic [DATA_W-1:0] ctrl_rd;

    assign ctrl_wr = {DEV_CODE, addr_q[ADDR_W-1:8], 1'b0};
    assign ctrl_rd = {DEV_CODE, addr_q[ADDR_W-1:8], 1'b1};

    // the command just finished was a byte write
    assign byte_sent = (state == ADDR_WRITE) || (state == DATA_WRITE) ||
                       (state == READ_START) || (state == DATA_READ)  ||
                       (state == STOP && wf);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            wf        <= 1'b0;
            nack_seen <= 1'b0;
            cmd_valid <= 1'b0;
            cmd       <= CMD_STOP;
            ack       <= 1'b0;
            ack_err   <= 1'b0;
            busy      <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            if (state == IDLE)
            begin
                if (wr || rd) // wr wins
                begin
                    wf        <= wr;
                    addr_q    <= addr;
                    wdata_q   <= wdata;
                    nack_seen <= 1'b0;
                    ack_err   <= 1'b0;
                    busy      <= 1'b1;
                    cmd_valid <= 1'b1;
                    cmd       <= CMD_START;
                    state     <= CTRL_WRITE;
                end
            end
            else if (cmd_done)
            begin
                cmd_valid <= 1'b1;
                if (byte_sent && nack)
                begin
                    // no ack from the slave, straight to stop
                    nack_seen <= 1'b1;
                    cmd       <= CMD_STOP;
                    state     <= ACKN;
                end
                else
                begin
                    case (state)
                        CTRL_WRITE:
                        begin
                            cmd      <= CMD_WRITE;
                            cmd_byte <= ctrl_wr;
                            state    <= ADDR_WRITE;
                        end
                        ADDR_WRITE:
                        begin
                            cmd      <= CMD_WRITE;
                            cmd_byte <= addr_q[7:0];
                            state    <= wf ? DATA_WRITE : READ_START;
                        end
                        DATA_WRITE:
                        begin
                            cmd      <= CMD_WRITE;
                            cmd_byte <= wdata_q;
                            state    <= STOP;
                        end
                        READ_START:
                        begin
                            cmd   <= CMD_START; // repeated start
                            state <= CTRL_READ;
                        end
                        CTRL_READ:
                        begin
                            cmd      <= CMD_WRITE;
                            cmd_byte <= ctrl_rd;
                            state    <= DATA_READ;
                        end
                        DATA_READ:
                        begin
                            cmd   <= CMD_READ;
                            state <= STOP;
                        end
                        STOP:
                        begin
                            cmd   <= CMD_STOP;
                            state <= ACKN;
                        end
                        ACKN:
                        begin
                            cmd_valid <= 1'b0;
                            ack       <= 1'b1;
                            ack_err   <= nack_seen;
                            busy      <= 1'b0;
                            state     <= IDLE;
                            if (!wf && !nack_seen)
                                rdata <= rx_byte;
                        end
                        default:
                        begin
                            cmd_valid <= 1'b0;
                            busy      <= 1'b0;
                            state     <= IDLE;
                        end
                    endcase
                end
            end
        end
    end

    // single outstanding command towards the bit engine
    a_cmd_valid_pulse: assert property (
        @(posedge CLK) disable iff (RESET) cmd_valid |=> !cmd_valid
    ) else $error("cmd_valid high in two consecutive cycles");

endmodule

/* logic/eeprom_i2c_top.sv */
`timescale 1ns/1ps

module eeprom_i2c_top #(
    parameter int SCL_HALF_CYCLES = 4 // clk cycles per scl half period
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    input  logic                          sda_in,
    output logic                          scl,
    output logic                          sda_low,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          ack,
    output logic                          ack_err,
    output logic                          busy
);
    import eeprom_pkg::*;

    logic              cmd_valid;
    i2c_cmd_t          cmd;
    logic [DATA_W-1:0] cmd_byte;
    logic              cmd_done;
    logic [DATA_W-1:0] rx_byte;
    logic              nack;

    eeprom_sequencer i_sequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .nack      (nack),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_byte  (cmd_byte),
        .rdata     (rdata),
        .ack       (ack),
        .ack_err   (ack_err),
        .busy      (busy)
    );

    i2c_bit_engine #(
        .SCL_HALF_CYCLES (SCL_HALF_CYCLES)
    ) i_bit_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_byte  (cmd_byte),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda_low   (sda_low),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .nack      (nack)
    );

endmodule

/* testbench/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic absent,      // device missing, never acknowledges
    output logic sda_release, // 0 pulls sda low
    output int   xfer_count,
    output int   proto_errors
);
    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg;
    logic [7:0]  txbyte;
    logic [10:0] ptr;
    logic        scl_q;
    logic        sda_q;
    int          bitcnt;
    int          phase; // 0 idle, 1 ctrl, 2 word addr, 3 data in, 4 data out, 5 done

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
        sda_release  = 1'b1;
        xfer_count   = 0;
        proto_errors = 0;
        bitcnt       = 0;
        phase        = 0;
        ptr          = '0;
        shreg        = '0;
        txbyte       = '0;
        scl_q        = 1'b1;
        sda_q        = 1'b1;
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            // start or stop, legal only between bytes
            if (phase != 0 && bitcnt > 1)
            begin
                $display("model: %s condition inside a byte", sda ? "stop" : "start");
                proto_errors++;
            end
            if (sda === 1'b0)
                phase = 1;
            else
            begin
                if (phase != 0)
                    xfer_count++;
                phase = 0;
            end
            bitcnt      = 0;
            sda_release = 1'b1;
        end
        else if (scl === 1'b1 && scl_q === 1'b0 && phase != 0)
        begin
            if (bitcnt < 8)
                shreg = {shreg[6:0], sda}; // msb first
            bitcnt = (bitcnt == 8) ? 0 : bitcnt + 1;
        end
        else if (scl === 1'b0 && scl_q === 1'b1 && phase != 0)
        begin
            sda_release = 1'b1;
            if (bitcnt == 8)
            begin
                case (phase)
                    1:
                    begin
                        if (!absent && shreg[7:4] == 4'b1010)
                        begin
                            sda_release = 1'b0;
                            ptr[10:8]   = shreg[3:1]; // block select bits
                            phase       = shreg[0] ? 4 : 2;
                        end
                        else
                            phase = 5;
                    end
                    2:
                    begin
                        sda_release = 1'b0;
                        ptr[7:0]    = shreg;
                        phase       = 3;
                    end
                    3:
                    begin
                        sda_release = 1'b0;
                        mem[ptr]    = shreg;
                        phase       = 5; // single byte only
                    end
                    default: phase = 5;
                endcase
            end
            else if (phase == 4)
            begin
                if (bitcnt == 0)
                    txbyte = mem[ptr];
                sda_release = txbyte[7 - bitcnt];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* testbench/tb_eeprom_i2c.sv */
`timescale 1ns/1ps

module tb_eeprom_i2c;
    import eeprom_pkg::*;

    localparam int SCL_HALF_CYCLES = 4;
    localparam int N_ENTRIES       = 13;
    localparam int CYCLE_LIMIT     = N_ENTRIES * 40 * 2 * SCL_HALF_CYCLES + 500;

    typedef struct packed {
        logic              is_read;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              absent;
        logic [DATA_W-1:0] exp_rdata;
    } entry_t;

    logic              CLK = 1'b0;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              scl;
    logic              sda_low;
    logic              sda;
    logic              sda_release;
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              ack_err;
    logic              busy;
    logic              model_absent;
    int                xfer_count;
    int                proto_errors;

    entry_t            stim [N_ENTRIES];
    logic [DATA_W-1:0] ref_mem [0:2**ADDR_W-1];
    logic [DATA_W-1:0] last_rdata;
    int                n_built;
    int                seed = 32'hc828;
    int                mismatches;
    int                cycles = 0;

    assign sda = !sda_low & sda_release; // open-drain bus

    always #2 CLK = ~CLK;

    eeprom_i2c_top #(
        .SCL_HALF_CYCLES (SCL_HALF_CYCLES)
    ) i_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .sda_in  (sda),
        .scl     (scl),
        .sda_low (sda_low),
        .rdata   (rdata),
        .ack     (ack),
        .ack_err (ack_err),
        .busy    (busy)
    );

    eeprom_model i_model (
        .scl          (scl),
        .sda          (sda),
        .absent       (model_absent),
        .sda_release  (sda_release),
        .xfer_count   (xfer_count),
        .proto_errors (proto_errors)
    );

    // same power-up contents as the model
    function automatic logic [DATA_W-1:0] fill_value(input int a);
        return 8'(a) ^ 8'(a >> 3) ^ 8'h5a;
    endfunction

    task automatic add_entry(input logic is_read, input logic [ADDR_W-1:0] a,
                             input logic absent);
        entry_t e;
        e.is_read = is_read;
        e.addr    = a;
        e.wdata   = 8'($random(seed));
        e.absent  = absent;
        if (!is_read && !absent)
            ref_mem[a] = e.wdata;
        if (is_read && !absent)
            last_rdata = ref_mem[a];
        e.exp_rdata   = last_rdata; // a failed read keeps the old byte
        stim[n_built] = e;
        n_built++;
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp)
        begin
            $display("FAILED %s expected %h got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAILED %s expected %h got %h", name, exp, act);
            mismatches++;
        end
    endtask

    // starts on a rising edge, returns at the falling edge where ack is high
    task automatic apply_request(input entry_t e);
        model_absent <= e.absent;
        addr         <= e.addr;
        wdata        <= e.wdata;
        wr           <= !e.is_read;
        rd           <= e.is_read;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        repeat (6) @(posedge CLK);
        wr    <= 1'b1; // must be ignored while busy
        wdata <= ~e.wdata;
        @(posedge CLK);
        wr <= 1'b0;
        @(negedge CLK);
        while (ack !== 1'b1)
            @(negedge CLK);
    endtask

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout, no ack from the DUT within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wdata        = '0;
        model_absent = 1'b0;
        mismatches   = 0;
        n_built      = 0;
        last_rdata   = '0;
        for (int i = 0; i < 2**ADDR_W; i++)
            ref_mem[i] = fill_value(i);

        add_entry(1'b0, 11'h123, 1'b0);
        add_entry(1'b1, 11'h123, 1'b0);
        add_entry(1'b0, 11'h023, 1'b0); // same word address, other blocks
        add_entry(1'b0, 11'h723, 1'b0);
        add_entry(1'b1, 11'h123, 1'b0);
        add_entry(1'b1, 11'h023, 1'b0);
        add_entry(1'b1, 11'h723, 1'b0);
        add_entry(1'b0, 11'h123, 1'b1); // no device on the bus
        add_entry(1'b1, 11'h123, 1'b1);
        add_entry(1'b1, 11'h123, 1'b0);
        add_entry(1'b0, 11'h5ff, 1'b0);
        add_entry(1'b1, 11'h5ff, 1'b0);
        add_entry(1'b1, 11'h3c4, 1'b0); // never written

        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_flag("scl", 1'b1, scl);
        check_flag("sda_low", 1'b0, sda_low);
        check_flag("ack", 1'b0, ack);
        check_flag("busy", 1'b0, busy);

        for (int i = 0; i < N_ENTRIES; i++)
        begin
            @(posedge CLK);
            apply_request(stim[i]);
            check_flag("busy", 1'b0, busy);
            check_flag("ack_err", stim[i].absent, ack_err);
            if (stim[i].is_read)
                check_data("rdata", stim[i].exp_rdata, rdata);
            @(negedge CLK);
            check_flag("ack", 1'b0, ack);
            check_flag("busy", 1'b0, busy);
            if (xfer_count != i + 1)
            begin
                $display("model counted %0d finished transactions after request %0d",
                         xfer_count, i + 1);
                mismatches++;
            end
        end

        $display("errors: %0d value mismatches, %0d bus protocol errors",
                 mismatches, proto_errors);
        if (mismatches == 0 && proto_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* eeprom_i2c.f */
logic/eeprom_pkg.sv
logic/i2c_bit_engine.sv
logic/eeprom_sequencer.sv
logic/eeprom_i2c_top.sv
testbench/eeprom_model.sv
testbench/tb_eeprom_i2c.sv

/* run_sim.sh */
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eeprom_i2c -Mdir obj_dir -f eeprom_i2c.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_eeprom_i2c > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
